/* Bender.yml */
package:
  name: cnn_classifier

export_include_dirs:
  - include

sources:
  - design/cnn_pkg.sv
  - design/cnn_ifs.sv
  - design/operand_ram.sv
  - design/mac_pe.sv
  - design/layer_sequencer.sv
  - design/cnn_classifier.sv
  - target: test
    files:
      - tb/tb_cnn_classifier.sv

/* cnn_classifier.f */
+incdir+include
design/cnn_pkg.sv
design/cnn_ifs.sv
design/operand_ram.sv
design/mac_pe.sv
design/layer_sequencer.sv
design/cnn_classifier.sv
tb/tb_cnn_classifier.sv

/* design/cnn_classifier.sv */
// CNN classifier top level with load port steering, operand buffers, PE and sequencer
`timescale 1ns/1ps
`include "cnn_config.svh"

module cnn_classifier import cnn_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    input  logic                    i_load_valid,
    input  buf_sel_t                i_load_sel,
    input  logic [`CNN_ADDR_W-1:0]  i_load_addr,
    input  pixel_t                  i_load_data,
    output logic                    o_busy,
    output logic                    o_done,
    output logic                    o_decision,
    output logic [`CNN_HISTORY-1:0] o_history
);

    localparam int BUF_DEPTH  = 1 << `CNN_ADDR_W;
    localparam int FEAT_DEPTH = `CNN_FMAP_DIM * `CNN_FMAP_DIM;

    logic seq_busy;

    // Indices follow buf_sel_t with the image buffer at 0 and the weight buffer at 1
    ram_if buf_seq_if [2] ();
    ram_if buf_mem_if [2] ();
    ram_if feat_if ();
    pe_if  pe_bus ();

    assign o_busy = seq_busy;

    //////////////////////////////////////////////////////////////////////
    // Image and weight buffers with load port steering
    //////////////////////////////////////////////////////////////////////
    for (genvar b = 0; b < 2; b++) begin : g_load_buf
        logic load_hit;

        // Loads only land while the sequencer is idle
        assign load_hit = i_load_valid && !seq_busy && (i_load_sel == buf_sel_t'(b));

        assign buf_mem_if[b].we    = seq_busy ? buf_seq_if[b].we    : load_hit;
        assign buf_mem_if[b].addr  = seq_busy ? buf_seq_if[b].addr  : i_load_addr;
        assign buf_mem_if[b].wdata = seq_busy ? buf_seq_if[b].wdata : i_load_data;
        assign buf_seq_if[b].rdata = buf_mem_if[b].rdata;

        operand_ram #(
            .DEPTH (BUF_DEPTH)
        ) i_operand_ram (
            .i_clk (i_clk),
            .bus   (buf_mem_if[b])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Feature buffer owned by the sequencer only
    //////////////////////////////////////////////////////////////////////
    operand_ram #(
        .DEPTH (FEAT_DEPTH)
    ) i_feat_ram (
        .i_clk (i_clk),
        .bus   (feat_if)
    );

    // Shared multiply-accumulate element
    mac_pe i_mac_pe (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .pe    (pe_bus)
    );

    //////////////////////////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////////////////////////
    layer_sequencer i_layer_sequencer (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .o_busy     (seq_busy),
        .o_done     (o_done),
        .o_decision (o_decision),
        .o_history  (o_history),
        .img_ram    (buf_seq_if[0]),
        .wgt_ram    (buf_seq_if[1]),
        .feat_ram   (feat_if),
        .pe         (pe_bus)
    );

endmodule

/* design/cnn_ifs.sv */
// CNN classifier interfaces for the buffer port and the processing element
`timescale 1ns/1ps
`include "cnn_config.svh"

//////////////////////////////////////////////////////////////////////
// Buffer port that writes on the clock edge and reads one cycle later
//////////////////////////////////////////////////////////////////////
interface ram_if;
    logic                   we;
    logic [`CNN_ADDR_W-1:0] addr;
    logic [`CNN_DATA_W-1:0] wdata;
    logic [`CNN_DATA_W-1:0] rdata;

    modport owner (
        output we, addr, wdata,
        input  rdata
    );

    modport mem (
        input  we, addr, wdata,
        output rdata
    );
endinterface

//////////////////////////////////////////////////////////////////////
// Processing element control and result
//////////////////////////////////////////////////////////////////////
interface pe_if;
    logic                          valid;
    logic                          clr;
    logic [`CNN_DATA_W-1:0]        data;
    logic signed [`CNN_DATA_W-1:0] weight;
    logic [`CNN_DATA_W-1:0]        result;
    logic                          positive;

    modport ctrl (
        output valid, clr, data, weight,
        input  result, positive
    );

    modport pe (
        input  valid, clr, data, weight,
        output result, positive
    );
endinterface

/* design/cnn_pkg.sv */
// CNN classifier package with controller states, load target select and data word types
`include "cnn_config.svh"

package cnn_pkg;

    //////////////////////////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [4:0] {
        ST_IDLE       = 5'd0,
        ST_CONV_ADDR  = 5'd1,
        ST_CONV_READ  = 5'd2,
        ST_CONV_MAC   = 5'd3,
        ST_CONV_WRITE = 5'd4,
        ST_DENSE_ADDR = 5'd5,
        ST_DENSE_READ = 5'd6,
        ST_DENSE_MAC  = 5'd7,
        ST_DECIDE     = 5'd8,
        ST_DONE       = 5'd9
    } seq_state_t;

    // Load port target
    typedef enum logic {
        BUF_IMAGE  = 1'b0,
        BUF_WEIGHT = 1'b1
    } buf_sel_t;

    //////////////////////////////////////////////////////////////////////
    // Data words
    //////////////////////////////////////////////////////////////////////

    // Unsigned pixel or feature
    typedef logic [`CNN_DATA_W-1:0] pixel_t;

    // Signed kernel or dense weight
    typedef logic signed [`CNN_DATA_W-1:0] weight_t;

    // Signed running sum
    typedef logic signed [`CNN_ACC_W-1:0] acc_t;

endpackage

/* design/layer_sequencer.sv */
// Layer sequencer FSM that scans the conv window and the dense pass through one PE
`timescale 1ns/1ps
`include "cnn_config.svh"

module layer_sequencer import cnn_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    output logic                    o_busy,
    output logic                    o_done,
    output logic                    o_decision,
    output logic [`CNN_HISTORY-1:0] o_history,
    ram_if.owner                    img_ram,
    ram_if.owner                    wgt_ram,
    ram_if.owner                    feat_ram,
    pe_if.ctrl                      pe
);

    localparam logic [2:0]             POS_LAST   = 3'(`CNN_FMAP_DIM - 1);
    localparam logic [1:0]             TAP_LAST   = 2'(`CNN_K_DIM - 1);
    localparam logic [`CNN_ADDR_W-1:0] DENSE_LAST =
        `CNN_ADDR_W'(`CNN_FMAP_DIM * `CNN_FMAP_DIM - 1);

    seq_state_t state;

    // Window position and kernel tap
    logic [2:0]             row;
    logic [2:0]             col;
    logic [1:0]             k_row;
    logic [1:0]             k_col;
    logic [`CNN_ADDR_W-1:0] dense_idx;

    logic                   last_tap;
    logic                   last_feat;
    logic                   last_dense;
    logic                   dense_phase;
    logic [`CNN_ADDR_W-1:0] conv_pix_addr;
    logic [`CNN_ADDR_W-1:0] conv_tap_addr;
    logic [`CNN_ADDR_W-1:0] conv_feat_addr;
    logic [`CNN_ADDR_W-1:0] dense_wgt_addr;

    //////////////////////////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////////////////////////

    // Window origin row*8+col plus tap offset k_row*8+k_col
    assign conv_pix_addr = (`CNN_ADDR_W'(row) + `CNN_ADDR_W'(k_row)) * `CNN_ADDR_W'(`CNN_IMG_DIM)
                         + `CNN_ADDR_W'(col) + `CNN_ADDR_W'(k_col);
    assign conv_tap_addr = `CNN_ADDR_W'(k_row) * `CNN_ADDR_W'(`CNN_K_DIM) + `CNN_ADDR_W'(k_col);
    assign conv_feat_addr = `CNN_ADDR_W'(row) * `CNN_ADDR_W'(`CNN_FMAP_DIM) + `CNN_ADDR_W'(col);
    assign dense_wgt_addr = `CNN_ADDR_W'(`CNN_DENSE_BASE) + dense_idx;

    assign last_tap   = (k_row == TAP_LAST) && (k_col == TAP_LAST);
    assign last_feat  = (row == POS_LAST) && (col == POS_LAST);
    assign last_dense = (dense_idx == DENSE_LAST);

    assign dense_phase = (state == ST_DENSE_ADDR) || (state == ST_DENSE_READ) ||
                         (state == ST_DENSE_MAC);

    // Image and weight buffers are read-only here
    assign img_ram.we    = 1'b0;
    assign img_ram.wdata = '0;
    assign img_ram.addr  = conv_pix_addr;

    assign wgt_ram.we    = 1'b0;
    assign wgt_ram.wdata = '0;
    assign wgt_ram.addr  = dense_phase ? dense_wgt_addr : conv_tap_addr;

    // Feature written once per window and read back in the dense pass
    assign feat_ram.we    = (state == ST_CONV_WRITE);
    assign feat_ram.wdata = pe.result;
    assign feat_ram.addr  = dense_phase ? dense_idx : conv_feat_addr;

    // PE control
    assign pe.valid = (state == ST_CONV_MAC) || (state == ST_DENSE_MAC);
    assign pe.clr   = (state == ST_CONV_WRITE) || (state == ST_DECIDE);

    assign o_busy = (state != ST_IDLE);
    assign o_done = (state == ST_DONE);

    // Latch operands the cycle read data arrives
    always_ff @(posedge i_clk) begin
        if ((state == ST_CONV_READ) || (state == ST_DENSE_READ)) begin
            pe.data   <= dense_phase ? feat_ram.rdata : img_ram.rdata;
            pe.weight <= weight_t'(wgt_ram.rdata);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Controller FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            row        <= '0;
            col        <= '0;
            k_row      <= '0;
            k_col      <= '0;
            dense_idx  <= '0;
            o_decision <= 1'b0;
            o_history  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        row       <= '0;
                        col       <= '0;
                        k_row     <= '0;
                        k_col     <= '0;
                        dense_idx <= '0;
                        state     <= ST_CONV_ADDR;
                    end
                end
                ST_CONV_ADDR: begin
                    state <= ST_CONV_READ;
                end
                ST_CONV_READ: begin
                    state <= ST_CONV_MAC;
                end
                ST_CONV_MAC: begin
                    if (last_tap) begin
                        k_row <= '0;
                        k_col <= '0;
                        state <= ST_CONV_WRITE;
                    end else begin
                        if (k_col == TAP_LAST) begin
                            k_col <= '0;
                            k_row <= k_row + 2'd1;
                        end else begin
                            k_col <= k_col + 2'd1;
                        end
                        state <= ST_CONV_ADDR;
                    end
                end
                ST_CONV_WRITE: begin
                    // Result of the ninth tap is stored this cycle
                    if (last_feat) begin
                        row       <= '0;
                        col       <= '0;
                        dense_idx <= '0;
                        state     <= ST_DENSE_ADDR;
                    end else begin
                        if (col == POS_LAST) begin
                            col <= '0;
                            row <= row + 3'd1;
                        end else begin
                            col <= col + 3'd1;
                        end
                        state <= ST_CONV_ADDR;
                    end
                end
                ST_DENSE_ADDR: begin
                    state <= ST_DENSE_READ;
                end
                ST_DENSE_READ: begin
                    state <= ST_DENSE_MAC;
                end
                ST_DENSE_MAC: begin
                    if (last_dense) begin
                        dense_idx <= '0;
                        state     <= ST_DECIDE;
                    end else begin
                        dense_idx <= dense_idx + 1'b1;
                        state     <= ST_DENSE_ADDR;
                    end
                end
                ST_DECIDE: begin
                    // Newest decision enters at bit 0
                    o_decision <= pe.positive;
                    o_history  <= {o_history[`CNN_HISTORY-2:0], pe.positive};
                    state      <= ST_DONE;
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/mac_pe.sv */
// MAC processing element with signed accumulate, ReLU, shift-quantize and saturate
`timescale 1ns/1ps
`include "cnn_config.svh"

module mac_pe import cnn_pkg::*; (
    input logic i_clk,
    input logic i_rst,
    pe_if.pe    pe
);

    localparam acc_t SAT_MAX = acc_t'((1 << `CNN_DATA_W) - 1);

    acc_t                      acc;
    acc_t                      product;
    acc_t                      shifted;
    logic signed [`CNN_DATA_W:0] data_ext;

    // Pixel is unsigned, so pad a zero sign bit before the signed multiply
    assign data_ext = {1'b0, pe.data};
    assign product  = data_ext * pe.weight;

    //////////////////////////////////////////////////////////////////////
    // Accumulator
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            acc <= '0;
        end else if (pe.clr) begin
            acc <= '0;
        end else if (pe.valid) begin
            acc <= acc + product;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////
    assign shifted = acc >>> `CNN_CONV_SHIFT;

    // ReLU first, then clamp the quantized value to one byte
    always_comb begin
        if (acc <= 0) begin
            pe.result = '0;
        end else if (shifted > SAT_MAX) begin
            pe.result = SAT_MAX[`CNN_DATA_W-1:0];
        end else begin
            pe.result = shifted[`CNN_DATA_W-1:0];
        end
    end

    // Dense decision needs a sum strictly above zero
    assign pe.positive = (acc > 0);

endmodule

/* design/operand_ram.sv */
// Single-port synchronous operand buffer with a registered read port
`timescale 1ns/1ps
`include "cnn_config.svh"

module operand_ram import cnn_pkg::*; #(
    parameter int DEPTH = 1 << `CNN_ADDR_W
) (
    input logic i_clk,
    ram_if.mem  bus
);

    // Storage array
    pixel_t mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registered read with data valid the cycle after addr
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        bus.rdata <= mem[bus.addr];
    end

endmodule

/* include/cnn_config.svh */
// CNN classifier configuration constants for image, kernel, quantize and buffer sizes
`ifndef CNN_CONFIG_SVH
`define CNN_CONFIG_SVH

// Image side in pixels (square input)
`define CNN_IMG_DIM 8

// Convolution kernel side
`define CNN_K_DIM 3

// Feature map side is the image minus the kernel plus one
`define CNN_FMAP_DIM 6

// Arithmetic right shift applied after ReLU
`define CNN_CONV_SHIFT 4

// Buffer address width covering the 64-word image and weight buffers
`define CNN_ADDR_W 6

// Pixels, weights and features are all one byte
`define CNN_DATA_W 8

// Accumulator width
`define CNN_ACC_W 20

// Dense weights follow the nine kernel taps
`define CNN_DENSE_BASE 9

// Decisions kept in the shift history
`define CNN_HISTORY 8

`endif

/* tb/tb_cnn_classifier.sv */
// CNN classifier testbench with random and corner-case runs checked against a reference model
`timescale 1ns/1ps
`include "cnn_config.svh"

module tb_cnn_classifier import cnn_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int IMG_WORDS   = `CNN_IMG_DIM * `CNN_IMG_DIM;
    localparam int TAPS        = `CNN_K_DIM * `CNN_K_DIM;
    localparam int FEATS       = `CNN_FMAP_DIM * `CNN_FMAP_DIM;
    localparam int WGT_WORDS   = `CNN_DENSE_BASE + FEATS;
    localparam int SAT_MAX     = (1 << `CNN_DATA_W) - 1;
    localparam int RUN_CYCLES  = FEATS * (TAPS * 3 + 1) + FEATS * 3 + 4;
    localparam int LOAD_CYCLES = IMG_WORDS + WGT_WORDS + 2;
    localparam int NUM_RUNS    = 8;
    // Five spare runs of margin on top of the scheduled ones
    localparam int WATCHDOG_CYCLES = (NUM_RUNS + 5) * (RUN_CYCLES + LOAD_CYCLES);

    logic                    i_clk;
    logic                    i_rst;
    logic                    i_start;
    logic                    i_load_valid;
    buf_sel_t                i_load_sel;
    logic [`CNN_ADDR_W-1:0]  i_load_addr;
    pixel_t                  i_load_data;
    logic                    o_busy;
    logic                    o_done;
    logic                    o_decision;
    logic [`CNN_HISTORY-1:0] o_history;

    int                      seed = 32'h40d3_46c4;
    pixel_t                  img_mem [IMG_WORDS];
    weight_t                 wgt_mem [WGT_WORDS];
    int                      feat_exp [FEATS];
    logic                    dec_exp;
    logic [`CNN_HISTORY-1:0] hist_exp;
    int                      runs = 0;
    int                      done_count = 0;

    cnn_classifier i_cnn_classifier (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Every cycle with o_done high counts so a long pulse shows up as extra
    always @(negedge i_clk) begin
        if (o_done) begin
            done_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        abort_run("Timeout: the classifier runs did not finish in the expected time");
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic flag_mismatch(input string msg);
        abort_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus data and loading
    ////////////////////////////////////////////////////////////////////
    task automatic fill_random();
        for (int a = 0; a < IMG_WORDS; a++) begin
            img_mem[a] = pixel_t'($random(seed));
        end
        for (int a = 0; a < WGT_WORDS; a++) begin
            wgt_mem[a] = weight_t'($random(seed));
        end
    endtask

    // Bright image with a positive kernel or random image with a negative kernel
    task automatic fill_kernel_corner(input bit negative);
        int mag;
        fill_random();
        if (!negative) begin
            for (int a = 0; a < IMG_WORDS; a++) begin
                img_mem[a] = pixel_t'(SAT_MAX);
            end
        end
        for (int t = 0; t < TAPS; t++) begin
            mag = 1 + ($random(seed) & 127);
            wgt_mem[t] = negative ? weight_t'(-mag) : weight_t'(16 + (mag & 63));
        end
    endtask

    task automatic load_word(input buf_sel_t sel, input int addr, input pixel_t data);
        @(negedge i_clk);
        i_load_valid = 1'b1;
        i_load_sel   = sel;
        i_load_addr  = `CNN_ADDR_W'(addr);
        i_load_data  = data;
    endtask

    task automatic load_buffers();
        for (int a = 0; a < IMG_WORDS; a++) begin
            load_word(BUF_IMAGE, a, img_mem[a]);
        end
        for (int a = 0; a < WGT_WORDS; a++) begin
            load_word(BUF_WEIGHT, a, pixel_t'(wgt_mem[a]));
        end
        @(negedge i_clk);
        i_load_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////
    task automatic predict();
        int sum;
        int dense_total;
        logic signed [`CNN_ACC_W-1:0] dense_acc;
        for (int r = 0; r < `CNN_FMAP_DIM; r++) begin
            for (int c = 0; c < `CNN_FMAP_DIM; c++) begin
                sum = 0;
                for (int kr = 0; kr < `CNN_K_DIM; kr++) begin
                    for (int kc = 0; kc < `CNN_K_DIM; kc++) begin
                        sum += int'(img_mem[(r + kr) * `CNN_IMG_DIM + c + kc])
                             * int'(wgt_mem[kr * `CNN_K_DIM + kc]);
                    end
                end
                // ReLU then shift and clamp to a byte
                if (sum <= 0) begin
                    feat_exp[r * `CNN_FMAP_DIM + c] = 0;
                end else if ((sum >>> `CNN_CONV_SHIFT) > SAT_MAX) begin
                    feat_exp[r * `CNN_FMAP_DIM + c] = SAT_MAX;
                end else begin
                    feat_exp[r * `CNN_FMAP_DIM + c] = sum >>> `CNN_CONV_SHIFT;
                end
            end
        end
        dense_total = 0;
        for (int i = 0; i < FEATS; i++) begin
            dense_total += feat_exp[i] * int'(wgt_mem[`CNN_DENSE_BASE + i]);
        end
        // Dense sum wraps at the accumulator width
        dense_acc = dense_total[`CNN_ACC_W-1:0];
        dec_exp   = (dense_acc > 0);
    endtask

    // A negative level selects the model features instead of a fixed value
    task automatic check_features(input int level);
        int got;
        int want;
        for (int i = 0; i < FEATS; i++) begin
            got  = int'(i_cnn_classifier.i_feat_ram.mem[i]);
            want = (level < 0) ? feat_exp[i] : level;
            assert (got == want)
                else flag_mismatch($sformatf("feature %0d is %0d, expected %0d", i, got, want));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // One run from start to done with optional loads while busy
    ////////////////////////////////////////////////////////////////////
    task automatic run_classifier(input bit disturb);
        @(negedge i_clk);
        assert (!o_busy) else flag_mismatch("o_busy high before start");
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        while (!o_done) begin
            assert (o_busy) else flag_mismatch("o_busy low between start and done");
            if (disturb) begin
                i_load_valid = 1'b1;
                i_load_sel   = buf_sel_t'($random(seed) & 1);
                i_load_addr  = `CNN_ADDR_W'($random(seed));
                i_load_data  = pixel_t'($random(seed));
            end
            @(negedge i_clk);
        end
        i_load_valid = 1'b0;
        runs++;
        hist_exp = {hist_exp[`CNN_HISTORY-2:0], dec_exp};
        assert (o_busy) else flag_mismatch("o_busy low during o_done");
        assert (o_decision == dec_exp)
            else flag_mismatch($sformatf("decision %0b, expected %0b", o_decision, dec_exp));
        assert (o_history == hist_exp)
            else flag_mismatch($sformatf("history %b, expected %b", o_history, hist_exp));
        check_features(-1);
        @(negedge i_clk);
        assert (!o_done && !o_busy) else flag_mismatch("o_done or o_busy still high after done");
        assert (done_count == runs)
            else flag_mismatch($sformatf("%0d done cycles after %0d runs", done_count, runs));
    endtask

    initial begin
        i_rst        = 1'b1;
        i_start      = 1'b0;
        i_load_valid = 1'b0;
        i_load_sel   = BUF_IMAGE;
        i_load_addr  = '0;
        i_load_data  = '0;
        hist_exp     = '0;
        repeat (5) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        assert (!o_done && !o_busy && !o_decision && o_history == '0)
            else flag_mismatch("outputs not zero after reset");

        // The third random run loads while busy and then repeats on the same buffers
        for (int n = 0; n < 5; n++) begin
            fill_random();
            load_buffers();
            predict();
            run_classifier(n == 2);
            if (n == 2) begin
                run_classifier(1'b0);
            end
        end

        // Saturation first and then ReLU clipping everything to zero
        fill_kernel_corner(1'b0);
        load_buffers();
        predict();
        run_classifier(1'b0);
        check_features(SAT_MAX);
        fill_kernel_corner(1'b1);
        load_buffers();
        predict();
        run_classifier(1'b0);
        check_features(0);
        assert (!o_decision) else flag_mismatch("decision set with all features zero");

        $display("=== PASS ===");
        $finish;
    end

endmodule
